// ==== rtl/mem_cfg_pkg.sv ====
// memory-stage sizing constants, imported by every RTL block and the testbench
`default_nettype none

package mem_cfg_pkg;

    // register data and memory beat width
    localparam int unsigned XLEN         = 64;
    localparam int unsigned MASK_W       = XLEN / 8;
    localparam int unsigned ADDR_W       = 12;
    localparam int unsigned REG_ADDR_W   = 5;

    // byte offset inside a beat and the beat index above it
    localparam int unsigned OFFSET_W     = $clog2(MASK_W);
    localparam int unsigned BEAT_ADDR_W  = ADDR_W - OFFSET_W;
    localparam int unsigned DMEM_WORDS   = 1 << BEAT_ADDR_W;

    // SRAM request queue depth, also the number of credits held by the stage
    localparam int unsigned DMEM_CREDITS = 4;
    localparam int unsigned RETIRE_DEPTH = 8;

    localparam int unsigned CREDIT_W     = $clog2(DMEM_CREDITS + 1);
    localparam int unsigned DQ_PTR_W     = $clog2(DMEM_CREDITS);
    localparam int unsigned DQ_CNT_W     = $clog2(DMEM_CREDITS + 1);
    localparam int unsigned RQ_PTR_W     = $clog2(RETIRE_DEPTH);
    localparam int unsigned RQ_CNT_W     = $clog2(RETIRE_DEPTH + 1);

endpackage

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
// load/store operation encodings, retire entry type and decode helpers for the memory stage
`default_nettype none

package lsu_pkg;

    import mem_cfg_pkg::*;

    // loads occupy 1..7, stores 8..11
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LD   = 4'd4,
        OP_LBU  = 4'd5,
        OP_LHU  = 4'd6,
        OP_LWU  = 4'd7,
        OP_SB   = 4'd8,
        OP_SH   = 4'd9,
        OP_SW   = 4'd10,
        OP_SD   = 4'd11
    } ls_op_e;

    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } access_size_e;

    // one in-flight instruction; data is the ALU value or the returned beat
    typedef struct packed {
        ls_op_e                op;
        logic [OFFSET_W-1:0]   offset;
        logic                  rd_ena;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       data;
    } rq_entry_t;

    function automatic logic op_is_load(ls_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
    endfunction

    function automatic logic op_is_store(ls_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    endfunction

    function automatic logic op_is_mem(ls_op_e op);
        return op_is_load(op) || op_is_store(op);
    endfunction

    // sign extension only for the narrow signed loads
    function automatic logic op_is_signed(ls_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW};
    endfunction

    function automatic access_size_e op_size(ls_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SZ_B;
            OP_LH, OP_LHU, OP_SH: return SZ_H;
            OP_LW, OP_LWU, OP_SW: return SZ_W;
            default:              return SZ_D;
        endcase
    endfunction

    // lane start inside the beat, low address bits below the size are ignored
    function automatic logic [OFFSET_W-1:0] lane_offset(access_size_e sz,
                                                        logic [OFFSET_W-1:0] off);
        case (sz)
            SZ_B:    return off;
            SZ_H:    return {off[2:1], 1'b0};
            SZ_W:    return {off[2], 2'b00};
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rtl/dmem_if.sv ====
// credited request/response bundle between the load/store unit and the data SRAM
`timescale 1ns/1ps
`default_nettype none

interface dmem_if import mem_cfg_pkg::*; ();

    // request side, one beat per request
    logic                   req_valid;
    logic                   req_we;
    logic [BEAT_ADDR_W-1:0] req_addr;
    logic [XLEN-1:0]        req_wdata;
    logic [MASK_W-1:0]      req_wmask;

    // single-cycle pulse, one queue slot freed
    logic                   credit_ret;

    // one response per request, in request order
    logic                   rsp_valid;
    logic [XLEN-1:0]        rsp_rdata;

    modport master (
        output req_valid, req_we, req_addr, req_wdata, req_wmask,
        input  credit_ret, rsp_valid, rsp_rdata
    );

    modport slave (
        input  req_valid, req_we, req_addr, req_wdata, req_wmask,
        output credit_ret, rsp_valid, rsp_rdata
    );

endinterface

`default_nettype wire

// ==== rtl/load_store_unit.sv ====
// memory-stage core: aligns stores, extracts loads, counts SRAM credits and retires in order
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import mem_cfg_pkg::*, lsu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  ls_op_e                in_op_i,
    input  logic [ADDR_W-1:0]     in_addr_i,
    input  logic [XLEN-1:0]       in_data_i,
    input  logic                  in_rd_ena_i,
    input  logic [REG_ADDR_W-1:0] in_rd_addr_i,
    dmem_if.master                dmem,
    output logic                  wb_valid_o,
    output logic                  wb_rd_ena_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic [XLEN-1:0]       wb_rd_data_o
);

    logic                  in_is_mem;
    logic                  push;
    logic                  pop;
    logic                  rsp_capture;

    // store alignment
    access_size_e          st_size;
    logic [OFFSET_W-1:0]   st_lane;
    logic [XLEN-1:0]       st_low;
    logic [MASK_W-1:0]     st_low_mask;

    // retire queue
    rq_entry_t             rq_entry [RETIRE_DEPTH];
    logic [RETIRE_DEPTH-1:0] rq_done;
    logic [RQ_PTR_W-1:0]   rq_head;
    logic [RQ_PTR_W-1:0]   rq_tail;
    logic [RQ_CNT_W-1:0]   rq_count;
    logic [CREDIT_W-1:0]   credit_cnt;

    logic                  rsp_hit;
    logic [RQ_PTR_W-1:0]   rsp_idx;

    // load extraction from the head entry
    rq_entry_t             head;
    access_size_e          ld_size;
    logic [OFFSET_W-1:0]   ld_lane;
    logic [XLEN-1:0]       ld_beat;
    logic                  ld_sign;
    logic [XLEN-1:0]       ld_value;

    assign in_is_mem = op_is_mem(in_op_i);

    // memory ops also need a free SRAM queue slot
    assign in_ready_o = (rq_count != RQ_CNT_W'(RETIRE_DEPTH))
                     && (!in_is_mem || (credit_cnt != CREDIT_W'(0)));
    assign push       = in_valid_i && in_ready_o;

    always_comb begin
        st_size = op_size(in_op_i);
        st_lane = lane_offset(st_size, in_addr_i[OFFSET_W-1:0]);
        case (st_size)
            SZ_B: begin
                st_low      = {{(XLEN-8){1'b0}}, in_data_i[7:0]};
                st_low_mask = 8'b0000_0001;
            end
            SZ_H: begin
                st_low      = {{(XLEN-16){1'b0}}, in_data_i[15:0]};
                st_low_mask = 8'b0000_0011;
            end
            SZ_W: begin
                st_low      = {{(XLEN-32){1'b0}}, in_data_i[31:0]};
                st_low_mask = 8'b0000_1111;
            end
            default: begin
                st_low      = in_data_i;
                st_low_mask = 8'b1111_1111;
            end
        endcase
    end

    // request goes out in the accept cycle
    assign dmem.req_valid = push && in_is_mem;
    assign dmem.req_we    = op_is_store(in_op_i);
    assign dmem.req_addr  = in_addr_i[ADDR_W-1:OFFSET_W];
    assign dmem.req_wdata = st_low << {st_lane, 3'b000};
    assign dmem.req_wmask = st_low_mask << st_lane;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= CREDIT_W'(DMEM_CREDITS);
        end else begin
            case ({dmem.req_valid, dmem.credit_ret})
                2'b10:   credit_cnt <= credit_cnt - CREDIT_W'(1);
                2'b01:   credit_cnt <= credit_cnt + CREDIT_W'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // responses arrive in request order, so the target is the oldest
    // memory entry that is still waiting
    always_comb begin
        logic [RQ_PTR_W-1:0] idx;
        rsp_hit = 1'b0;
        rsp_idx = rq_head;
        for (int i = 0; i < RETIRE_DEPTH; i++) begin
            idx = rq_head + RQ_PTR_W'(i);
            if (!rsp_hit && (RQ_CNT_W'(i) < rq_count)
                    && op_is_mem(rq_entry[idx].op) && !rq_done[idx]) begin
                rsp_hit = 1'b1;
                rsp_idx = idx;
            end
        end
    end

    assign rsp_capture = dmem.rsp_valid && rsp_hit;

    assign head = rq_entry[rq_head];
    assign pop  = (rq_count != RQ_CNT_W'(0)) && rq_done[rq_head];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rq_head  <= '0;
            rq_tail  <= '0;
            rq_count <= '0;
            rq_done  <= '0;
        end else begin
            if (push) begin
                rq_tail          <= rq_tail + RQ_PTR_W'(1);
                // pass-through entries are complete on arrival
                rq_done[rq_tail] <= !in_is_mem;
            end
            if (rsp_capture) begin
                rq_done[rsp_idx] <= 1'b1;
            end
            if (pop) begin
                rq_head <= rq_head + RQ_PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   rq_count <= rq_count + RQ_CNT_W'(1);
                2'b01:   rq_count <= rq_count - RQ_CNT_W'(1);
                default: rq_count <= rq_count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            rq_entry[rq_tail] <= '{op:      in_op_i,
                                   offset:  in_addr_i[OFFSET_W-1:0],
                                   rd_ena:  in_rd_ena_i,
                                   rd_addr: in_rd_addr_i,
                                   data:    in_data_i};
        end
        // store beats land here too and are never written back
        if (rsp_capture) begin
            rq_entry[rsp_idx].data <= dmem.rsp_rdata;
        end
    end

    always_comb begin
        ld_size = op_size(head.op);
        ld_lane = lane_offset(ld_size, head.offset);
        ld_beat = head.data >> {ld_lane, 3'b000};
        ld_sign = op_is_signed(head.op);
        case (ld_size)
            SZ_B:    ld_value = {{(XLEN-8){ld_sign & ld_beat[7]}}, ld_beat[7:0]};
            SZ_H:    ld_value = {{(XLEN-16){ld_sign & ld_beat[15]}}, ld_beat[15:0]};
            SZ_W:    ld_value = {{(XLEN-32){ld_sign & ld_beat[31]}}, ld_beat[31:0]};
            default: ld_value = ld_beat;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o  <= 1'b0;
            wb_rd_ena_o <= 1'b0;
        end else begin
            wb_valid_o  <= pop;
            // stores never write a register
            wb_rd_ena_o <= pop && head.rd_ena && !op_is_store(head.op);
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            wb_rd_addr_o <= head.rd_addr;
            wb_rd_data_o <= op_is_load(head.op) ? ld_value : head.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/data_sram.sv ====
// byte-masked data memory behind a credited request queue, serves one access per cycle
`timescale 1ns/1ps
`default_nettype none

module data_sram import mem_cfg_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  logic   hold_i,
    dmem_if.slave  dmem
);

    logic [XLEN-1:0]          mem_array [DMEM_WORDS];

    // request queue, sized to the credit count so it cannot overflow
    logic [DMEM_CREDITS-1:0]  q_we;
    logic [BEAT_ADDR_W-1:0]   q_addr  [DMEM_CREDITS];
    logic [XLEN-1:0]          q_wdata [DMEM_CREDITS];
    logic [MASK_W-1:0]        q_wmask [DMEM_CREDITS];

    logic [DQ_PTR_W-1:0]      dq_head;
    logic [DQ_PTR_W-1:0]      dq_tail;
    logic [DQ_CNT_W-1:0]      dq_count;
    logic                     push;
    logic                     service;

    assign push    = dmem.req_valid;
    // hold models bank contention and stalls the head
    assign service = (dq_count != DQ_CNT_W'(0)) && !hold_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dq_head         <= '0;
            dq_tail         <= '0;
            dq_count        <= '0;
            dmem.rsp_valid  <= 1'b0;
            dmem.credit_ret <= 1'b0;
        end else begin
            if (push) begin
                dq_tail <= dq_tail + DQ_PTR_W'(1);
            end
            if (service) begin
                dq_head <= dq_head + DQ_PTR_W'(1);
            end
            case ({push, service})
                2'b10:   dq_count <= dq_count + DQ_CNT_W'(1);
                2'b01:   dq_count <= dq_count - DQ_CNT_W'(1);
                default: dq_count <= dq_count;
            endcase
            // slot freed and response produced at the same edge
            dmem.rsp_valid  <= service;
            dmem.credit_ret <= service;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            q_we[dq_tail]    <= dmem.req_we;
            q_addr[dq_tail]  <= dmem.req_addr;
            q_wdata[dq_tail] <= dmem.req_wdata;
            q_wmask[dq_tail] <= dmem.req_wmask;
        end
        if (service) begin
            if (q_we[dq_head]) begin
                for (int b = 0; b < MASK_W; b++) begin
                    if (q_wmask[dq_head][b]) begin
                        mem_array[q_addr[dq_head]][b*8 +: 8] <= q_wdata[dq_head][b*8 +: 8];
                    end
                end
            end
            // stores also return the old beat, the unit ignores it
            dmem.rsp_rdata <= mem_array[q_addr[dq_head]];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage_top.sv ====
// memory-access stage top level, joins the load/store unit to the data SRAM
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top import mem_cfg_pkg::*, lsu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // instruction from execute
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  ls_op_e                in_op_i,
    input  logic [ADDR_W-1:0]     in_addr_i,
    input  logic [XLEN-1:0]       in_data_i,
    input  logic                  in_rd_ena_i,
    input  logic [REG_ADDR_W-1:0] in_rd_addr_i,

    // bank contention, stalls SRAM servicing
    input  logic                  dmem_hold_i,

    // writeback, always accepted
    output logic                  wb_valid_o,
    output logic                  wb_rd_ena_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic [XLEN-1:0]       wb_rd_data_o
);

    dmem_if u_dmem_if ();

    load_store_unit u_lsu (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_addr_i    (in_addr_i),
        .in_data_i    (in_data_i),
        .in_rd_ena_i  (in_rd_ena_i),
        .in_rd_addr_i (in_rd_addr_i),
        .dmem         (u_dmem_if.master),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_ena_o  (wb_rd_ena_o),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_rd_data_o (wb_rd_data_o)
    );

    data_sram u_sram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .hold_i   (dmem_hold_i),
        .dmem     (u_dmem_if.slave)
    );

endmodule

`default_nettype wire

// ==== dv/mem_stage_tasks.svh ====
// drive, wait and compare tasks, included inside the memory-stage testbench module

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
endtask

task automatic check_wb_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("ERROR @ %0t: wb_rd_data_o = %h, expected %h", $time, got, exp));
    end
endtask

task automatic check_wb_dest(input logic got_ena, input logic exp_ena,
                             input logic [REG_ADDR_W-1:0] got_addr,
                             input logic [REG_ADDR_W-1:0] exp_addr);
    if (got_ena !== exp_ena || got_addr !== exp_addr) begin
        fail_run($sformatf("ERROR @ %0t: rd enable/index = %b/%0d, expected %b/%0d",
                           $time, got_ena, got_addr, exp_ena, exp_addr));
    end
endtask

// offer one instruction from the current rising edge until it is taken
task automatic issue(input ls_op_e op, input logic [ADDR_W-1:0] addr,
                     input logic [XLEN-1:0] data, input logic rd_ena,
                     input logic [REG_ADDR_W-1:0] rd, input int lat, output int waited);
    in_valid_i   <= 1'b1;
    in_op_i      <= op;
    in_addr_i    <= addr;
    in_data_i    <= data;
    in_rd_ena_i  <= rd_ena;
    in_rd_addr_i <= rd;
    waited = 0;
    @(posedge clk_i);
    while (in_ready_o !== 1'b1) begin
        waited++;
        if (waited > TIMEOUT) begin
            fail_run("timeout waiting for in_ready_o to accept an instruction");
        end
        @(posedge clk_i);
    end
    model_accept(op, addr, data, rd_ena, rd, lat);
endtask

task automatic idle();
    in_valid_i <= 1'b0;
endtask

task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            fail_run("timeout waiting for outstanding instructions to write back");
        end
        @(posedge clk_i);
    end
endtask

// ==== dv/mem_stage_tb.sv ====
// memory-stage testbench that runs directed tests against a byte-level reference memory
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb import mem_cfg_pkg::*, lsu_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int TIMEOUT    = 200;

    // one expected writeback
    // due is the negedge sample time, zero when the latency is not checked
    typedef struct packed {
        logic                  ena;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
        logic                  chk;
        logic [63:0]           due;
    } exp_t;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  in_valid_i;
    logic                  in_ready_o;
    ls_op_e                in_op_i;
    logic [ADDR_W-1:0]     in_addr_i;
    logic [XLEN-1:0]       in_data_i;
    logic                  in_rd_ena_i;
    logic [REG_ADDR_W-1:0] in_rd_addr_i;
    logic                  dmem_hold_i;
    logic                  wb_valid_o;
    logic                  wb_rd_ena_o;
    logic [REG_ADDR_W-1:0] wb_rd_addr_o;
    logic [XLEN-1:0]       wb_rd_data_o;

    logic [7:0]            ref_mem [1 << ADDR_W];
    exp_t                  exp_q [$];
    exp_t                  retired;
    integer                seed;

    `include "mem_stage_tasks.svh"

    mem_stage_top UUT (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_addr_i    (in_addr_i),
        .in_data_i    (in_data_i),
        .in_rd_ena_i  (in_rd_ena_i),
        .in_rd_addr_i (in_rd_addr_i),
        .dmem_hold_i  (dmem_hold_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_ena_o  (wb_rd_ena_o),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_rd_data_o (wb_rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int op_bytes(input ls_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            default:              return 8;
        endcase
    endfunction

    // stores update the model bytes and loads read them in program order at acceptance
    task automatic model_accept(input ls_op_e op, input logic [ADDR_W-1:0] addr,
                                input logic [XLEN-1:0] data, input logic rd_ena,
                                input logic [REG_ADDR_W-1:0] rd, input int lat);
        int                     n;
        logic                   sgn;
        logic [ADDR_W-1:0]      base;
        logic signed [XLEN-1:0] shifted;
        exp_t                   e;
        n     = op_bytes(op);
        sgn   = (op == OP_LB) || (op == OP_LH) || (op == OP_LW);
        base  = addr & ~ADDR_W'(n - 1);
        e.ena  = rd_ena;
        e.addr = rd;
        e.data = data;
        e.chk  = 1'b1;
        e.due  = (lat == 0) ? 64'd0 : 64'($time) + 64'(lat * CLK_PERIOD + CLK_PERIOD / 2);
        case (op)
            OP_NONE: begin
            end
            OP_SB, OP_SH, OP_SW, OP_SD: begin
                for (int i = 0; i < n; i++) begin
                    ref_mem[base + ADDR_W'(i)] = 8'(data >> (8 * i));
                end
                e.ena = 1'b0;
                e.chk = 1'b0;
            end
            default: begin
                e.data = '0;
                for (int i = n - 1; i >= 0; i--) begin
                    e.data = (e.data << 8) | XLEN'(ref_mem[base + ADDR_W'(i)]);
                end
                shifted = e.data << (XLEN - 8 * n);
                if (sgn) begin
                    e.data = shifted >>> (XLEN - 8 * n);
                end
            end
        endcase
        exp_q.push_back(e);
    endtask

    // each writeback is matched against the oldest expected entry
    always @(negedge clk_i) begin
        if (arst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                fail_run("writeback seen with no instruction outstanding");
            end else begin
                retired = exp_q.pop_front();
                check_wb_dest(wb_rd_ena_o, retired.ena, wb_rd_addr_o, retired.addr);
                if (retired.chk) begin
                    check_wb_data(wb_rd_data_o, retired.data);
                end
                if (retired.due != 64'd0 && 64'($time) != retired.due) begin
                    fail_run($sformatf("ERROR @ %0t: writeback late or early, expected at %0d",
                                       $time, retired.due));
                end
            end
        end
    end

    task automatic pass_through_burst();
        int w;
        for (int i = 0; i < 6; i++) begin
            issue(OP_NONE, '0, rand64(), i[0], REG_ADDR_W'(i + 1), 1, w);
        end
        idle();
        wait_drain();
    endtask

    task automatic store_then_load();
        logic [ADDR_W-1:0] beat;
        int                w;
        beat = 12'h100;
        issue(OP_SD, beat, rand64(), 1'b1, 5'd3, 0, w);
        for (int o = 0; o < 8; o++) begin
            issue(OP_SB, beat + ADDR_W'(o), rand64(), 1'b1, 5'd4, 0, w);
        end
        for (int o = 0; o < 8; o += 2) begin
            issue(OP_SH, beat + ADDR_W'(o), rand64(), 1'b1, 5'd5, 0, w);
        end
        for (int o = 0; o < 8; o += 4) begin
            issue(OP_SW, beat + ADDR_W'(o), rand64(), 1'b1, 5'd6, 0, w);
        end
        issue(OP_LD, beat, '0, 1'b1, 5'd7, 0, w);
        idle();
        wait_drain();
        // lone load on an idle stage
        issue(OP_LD, beat, '0, 1'b1, 5'd8, 3, w);
        idle();
        wait_drain();
    endtask

    task automatic sweep_load_extension();
        logic [ADDR_W-1:0] beat;
        int                w;
        beat = 12'h200;
        issue(OP_SD, beat, rand64() | 64'h8080_8080_8080_8080, 1'b0, '0, 0, w);
        for (int o = 0; o < 8; o++) begin
            issue(OP_LB, beat + ADDR_W'(o), '0, 1'b1, REG_ADDR_W'(o), 0, w);
            issue(OP_LBU, beat + ADDR_W'(o), '0, 1'b1, REG_ADDR_W'(o + 8), 0, w);
        end
        for (int o = 0; o < 8; o += 2) begin
            issue(OP_LH, beat + ADDR_W'(o), '0, 1'b1, REG_ADDR_W'(o + 16), 0, w);
            issue(OP_LHU, beat + ADDR_W'(o), '0, 1'b1, REG_ADDR_W'(o + 17), 0, w);
        end
        for (int o = 0; o < 8; o += 4) begin
            issue(OP_LW, beat + ADDR_W'(o), '0, 1'b1, REG_ADDR_W'(o + 24), 0, w);
            issue(OP_LWU, beat + ADDR_W'(o), '0, 1'b1, REG_ADDR_W'(o + 25), 0, w);
        end
        idle();
        wait_drain();
    endtask

    task automatic mixed_issue_order();
        logic [ADDR_W-1:0] a;
        int                w;
        int                kind;
        for (int i = 0; i < 4; i++) begin
            issue(OP_SD, 12'h300 + ADDR_W'(8 * i), rand64(), 1'b1, REG_ADDR_W'(i), 0, w);
        end
        for (int i = 0; i < 16; i++) begin
            kind = $unsigned($random(seed)) % 4;
            a    = 12'h300 + ADDR_W'(4 * ($unsigned($random(seed)) % 8));
            case (kind)
                0:       issue(OP_NONE, a, rand64(), 1'b1, REG_ADDR_W'(i), 0, w);
                1:       issue(OP_SW, a, rand64(), 1'b1, REG_ADDR_W'(i), 0, w);
                2:       issue(OP_LW, a, '0, 1'b1, REG_ADDR_W'(i), 0, w);
                default: issue(OP_LHU, a, '0, 1'b1, REG_ADDR_W'(i), 0, w);
            endcase
        end
        idle();
        wait_drain();
    endtask

    task automatic credit_backpressure();
        int w;
        dmem_hold_i <= 1'b1;
        for (int i = 0; i < DMEM_CREDITS; i++) begin
            issue(OP_LD, 12'h300 + ADDR_W'(8 * i), '0, 1'b1, REG_ADDR_W'(i + 10), 0, w);
            if (w != 0) begin
                fail_run("memory operation stalled while credits remained");
            end
        end
        // with no credit left a further load must wait
        in_op_i   <= OP_LD;
        in_addr_i <= 12'h300;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            if (in_ready_o !== 1'b0) begin
                fail_run($sformatf("ERROR @ %0t: in_ready_o high with no credit left", $time));
            end
        end
        issue(OP_NONE, '0, rand64(), 1'b1, 5'd20, 0, w);
        if (w != 0) begin
            fail_run("pass-through refused while the retire queue had room");
        end
        dmem_hold_i <= 1'b0;
        issue(OP_LD, 12'h308, '0, 1'b1, 5'd21, 0, w);
        idle();
        wait_drain();
    endtask

    initial begin
        seed = 32'h00e6d17b;
        arst_n_i     <= 1'b0;
        in_valid_i   <= 1'b0;
        in_op_i      <= OP_NONE;
        in_addr_i    <= '0;
        in_data_i    <= '0;
        in_rd_ena_i  <= 1'b0;
        in_rd_addr_i <= '0;
        dmem_hold_i  <= 1'b0;
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        if (in_ready_o !== 1'b1 || wb_valid_o !== 1'b0) begin
            fail_run($sformatf("ERROR @ %0t: stage not idle after reset", $time));
        end
        pass_through_burst();
        store_then_load();
        sweep_load_extension();
        mixed_issue_order();
        credit_backpressure();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
rtl/mem_cfg_pkg.sv
rtl/lsu_pkg.sv
rtl/dmem_if.sv
rtl/load_store_unit.sv
rtl/data_sram.sv
rtl/mem_stage_top.sv
dv/mem_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the memory-stage testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mem_stage_tb -f compile.f \
    --Mdir obj_dir -o mem_stage_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/mem_stage_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit "$status"
